// ==== cache_subsys.f ====
design/cache_pkg.sv
design/cache_ram.sv
design/l1_cache.sv
design/bus_arbiter.sv
design/cache_subsys.sv
testbench/tb_clock.sv
testbench/tb_cache_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the cache subsystem testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cache_subsys \
    -f cache_subsys.f -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== testbench/tb_cache_subsys.sv ====
`timescale 1ns/1ns
`default_nettype none

// random accesses on both ports, checked against a model of memory and of both caches
module tb_cache_subsys
    import cache_pkg::*;
();

    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] SEED       = 32'hfe3974b5;

    logic              clk;
    logic              rstn;
    logic              i_req;
    core_req_t         i_cmd;
    logic              i_busy;
    logic [DATA_W-1:0] i_rdata;
    logic              i_err;
    logic              d_req;
    core_req_t         d_cmd;
    logic              d_busy;
    logic [DATA_W-1:0] d_rdata;
    logic              d_err;
    logic              flush;
    mem_req_t          mem_req;
    logic              mem_req_valid;
    logic              mem_req_ready;
    mem_rsp_t          mem_rsp;

    logic [31:0]       stim_state;
    logic [31:0]       rsp_state;
    int                error_count;
    int                check_count;
    int                test_count;
    mem_req_t          bus_log [$];                        // requests accepted by the responder
    logic [DATA_W-1:0] mem_store [logic [ADDR_W-1:0]];     // responder contents
    logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];       // model contents
    logic [DATA_W-1:0] mline [2][LINES][WORDS_PER_LINE];
    logic [TAG_W-1:0]  mtag [2][LINES];
    logic              mvalid [2][LINES];
    int                rsp_phase;
    int                rsp_beat;
    int                rsp_delay;
    mem_req_t          rsp_req;
    logic [ADDR_W-1:0] rsp_addr;

    tb_clock clock_i (
        .clk  (clk),
        .rstn (rstn)
    );

    cache_subsys cache_subsys_i (
        .clk (clk), .rstn (rstn),
        .i_req (i_req), .i_cmd (i_cmd), .i_busy (i_busy), .i_rdata (i_rdata), .i_err (i_err),
        .d_req (d_req), .d_cmd (d_cmd), .d_busy (d_busy), .d_rdata (d_rdata), .d_err (d_err),
        .flush (flush),
        .mem_req (mem_req), .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready), .mem_rsp (mem_rsp)
    );

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = lcg(stim_state);
        return stim_state;
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] wdata,
                                                      input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return res;
    endfunction

    // unwritten words read back as their own address
    function automatic logic [DATA_W-1:0] ref_word(input logic [ADDR_W-1:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : a;
    endfunction

    function automatic logic [DATA_W-1:0] store_word(input logic [ADDR_W-1:0] a);
        return mem_store.exists(a) ? mem_store[a] : a;
    endfunction

    // four lines, four tags, bit 31 now and then for a bus error
    function automatic core_req_t random_cmd(input bit reads_only);
        core_req_t   c;
        logic [31:0] r;
        logic [3:0]  kind;
        r        = next_rand();
        kind     = r[21:18];
        c.addr   = {(!reads_only && r[31:28] == 4'h0), 19'd0, r[27:26], 4'd0, r[25:24],
                    r[23:22], 2'b00};
        c.wr     = !reads_only && kind >= 4'd9 && kind < 4'd13;
        c.bypass = !reads_only && kind >= 4'd13;
        c.wdata  = next_rand();
        c.strb   = r[17:14];
        return c;
    endfunction

    task automatic note_failure(input string msg);
        error_count++;
        $display("** Failure at %0t ns: %s", $time, msg);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_busy(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp);
        mem_req_t g;
        mem_req_t e;
        g = got;
        e = exp;
        if (e.op == MEM_READ) begin  // data and strobes carry no meaning on a read
            g.wdata = '0;
            g.strb  = '0;
            e.wdata = '0;
            e.strb  = '0;
        end
        check_count++;
        if (g !== e) begin
            error_count++;
            $display("** Error at %0t ns: %s got %h expected %h", $time, name, g, e);
        end
    endtask

    // predicts one access on port p and moves the model past it
    task automatic model_access(input int p, input core_req_t c, output logic need,
                                output mem_req_t er, output logic [DATA_W-1:0] ed,
                                output logic ee);
        logic [IDX_W-1:0]  idx;
        logic [TAG_W-1:0]  tag;
        logic [1:0]        w;
        logic [ADDR_W-1:0] wa;
        logic [ADDR_W-1:0] la;
        logic              hit;
        idx     = c.addr[OFS_W +: IDX_W];
        tag     = c.addr[ADDR_W-1 -: TAG_W];
        w       = c.addr[3:2];
        wa      = {c.addr[ADDR_W-1:2], 2'b00};
        la      = {c.addr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
        hit     = mvalid[p][idx] && mtag[p][idx] == tag;
        ee      = c.addr[ADDR_W-1];
        ed      = ref_word(wa);
        need    = 1'b1;
        er      = '0;
        er.op   = MEM_READ;
        er.addr = c.addr;
        if (c.wr) begin
            er.op    = MEM_WRITE;
            er.wdata = c.wdata;
            er.strb  = c.strb;
            if (!ee) begin
                ref_mem[wa] = merge_bytes(ed, c.wdata, c.strb);
                if (hit) mline[p][idx][w] = merge_bytes(mline[p][idx][w], c.wdata, c.strb);
            end
        end else if (!c.bypass) begin
            if (hit) begin
                need = 1'b0;
                ed   = mline[p][idx][w];  // may be stale after a write on the other port
            end else begin
                er.addr = la;
                er.len  = 2'd3;
                mvalid[p][idx] = !ee;
                mtag[p][idx]   = tag;
                for (int k = 0; k < WORDS_PER_LINE; k++) begin
                    mline[p][idx][k] = ref_word(la + ADDR_W'(4 * k));
                end
            end
        end
    endtask

    task automatic run_ops(input logic [1:0] act, input core_req_t c0, input core_req_t c1);
        core_req_t         cmd [2];
        logic              need [2];
        mem_req_t          exp_req [2];
        logic [DATA_W-1:0] exp_data [2];
        logic              exp_err [2];
        mem_req_t          order [$];
        int                cyc;
        cmd[0] = c0;
        cmd[1] = c1;
        for (int p = 0; p < 2; p++) begin
            need[p] = 1'b0;
            if (act[p]) begin
                model_access(p, cmd[p], need[p], exp_req[p], exp_data[p], exp_err[p]);
                if (need[p]) order.push_back(exp_req[p]);
            end
        end
        bus_log.delete();
        @(negedge clk);
        i_req = act[0];
        i_cmd = c0;
        d_req = act[1];
        d_cmd = c1;
        @(negedge clk);
        i_req = 1'b0;
        d_req = 1'b0;
        if (act[0]) check_busy("i_busy", i_busy, need[0]);  // a read hit answers right here
        if (act[1]) check_busy("d_busy", d_busy, need[1]);
        for (cyc = 0; ((act[0] && i_busy) || (act[1] && d_busy)) && cyc < WAIT_LIMIT; cyc++)
            @(negedge clk);
        if ((act[0] && i_busy) || (act[1] && d_busy)) begin
            abort_run("a cache stayed busy past the wait limit");
        end else begin
            if (act[0]) check_err("i_err", i_err, exp_err[0]);
            if (act[0] && !c0.wr && !exp_err[0]) check_word("i_rdata", i_rdata, exp_data[0]);
            if (act[1]) check_err("d_err", d_err, exp_err[1]);
            if (act[1] && !c1.wr && !exp_err[1]) check_word("d_rdata", d_rdata, exp_data[1]);
            if (bus_log.size() != order.size()) begin
                note_failure($sformatf("expected %0d bus requests but saw %0d",
                                       order.size(), bus_log.size()));
            end else begin
                // either port may win the bus first
                if (order.size() == 2 && bus_log[0].addr != order[0].addr) order.reverse();
                for (int k = 0; k < order.size(); k++) check_req("mem_req", bus_log[k], order[k]);
            end
        end
    endtask

    task automatic pulse_flush();
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        for (int p = 0; p < 2; p++) begin
            for (int l = 0; l < LINES; l++) mvalid[p][l] = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        $display("test %-10s finished with %0d errors", name, error_count - errs_before);
    endtask

    // memory side: ready after 0 to 3 cycles, then one beat per cycle
    always @(negedge clk) begin
        if (!rstn) begin
            mem_req_ready = 1'b0;
            mem_rsp       = '0;
            rsp_phase     = 0;
        end else begin
            mem_rsp = '0;
            if (rsp_phase == 0 && mem_req_valid) begin
                rsp_state = lcg(rsp_state);
                rsp_delay = int'(rsp_state[31:30]);
                rsp_phase = 1;
            end
            if (rsp_phase == 1) begin
                if (rsp_delay == 0) begin
                    mem_req_ready = 1'b1;
                    rsp_req       = mem_req;  // the request changes once it is taken
                    rsp_phase     = 2;
                end else begin
                    rsp_delay--;
                end
            end else if (rsp_phase == 2) begin
                mem_req_ready = 1'b0;
                bus_log.push_back(rsp_req);
                rsp_beat  = 0;
                rsp_phase = 3;
            end
            if (rsp_phase == 3) begin
                if (mem_req_valid) note_failure("bus request raised before the last beat");
                rsp_addr      = {rsp_req.addr[ADDR_W-1:2], 2'b00} + ADDR_W'(4 * rsp_beat);
                mem_rsp.valid = 1'b1;
                mem_rsp.err   = rsp_req.addr[ADDR_W-1];
                mem_rsp.last  = rsp_req.op == MEM_WRITE || rsp_beat == int'(rsp_req.len);
                mem_rsp.rdata = store_word(rsp_addr);
                if (rsp_req.op == MEM_WRITE && !mem_rsp.err) begin
                    mem_store[rsp_addr] = merge_bytes(store_word(rsp_addr), rsp_req.wdata,
                                                      rsp_req.strb);
                end
                if (mem_rsp.last) rsp_phase = 0;
                else rsp_beat++;
            end
        end
    end

    initial begin
        int          errs;
        int          cyc;
        logic [31:0] r;
        core_req_t   c0;
        core_req_t   c1;
        i_req         = 1'b0;
        i_cmd         = '0;
        d_req         = 1'b0;
        d_cmd         = '0;
        flush         = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp       = '0;
        stim_state    = SEED;
        rsp_state     = lcg(SEED);
        error_count   = 0;
        check_count   = 0;
        test_count    = 0;
        for (int p = 0; p < 2; p++) begin
            for (int l = 0; l < LINES; l++) mvalid[p][l] = 1'b0;
        end
        for (cyc = 0; !rstn && cyc < 100; cyc++) @(negedge clk);
        if (!rstn) begin
            abort_run("reset was never released");
        end else begin
            errs = error_count;
            for (int n = 0; n < 300; n++) begin
                c0 = random_cmd(1'b0);
                r  = next_rand();
                if (r[30]) run_ops(2'b10, '0, c0);
                else run_ops(2'b01, c0, '0);
            end
            report_test("random_mix", errs);

            errs = error_count;
            for (int n = 0; n < 20; n++) begin
                c0       = random_cmd(1'b1);
                c1       = c0;
                c1.wr    = 1'b1;
                c1.wdata = next_rand();
                r        = next_rand();
                c1.strb  = r[19:16];
                if (r[31]) run_ops(2'b10, '0, c1);
                else run_ops(2'b01, c1, '0);
                run_ops(2'b01, c0, '0);
                run_ops(2'b10, '0, c0);
            end
            report_test("write_read", errs);

            errs = error_count;
            for (int n = 0; n < 8; n++) begin
                c0      = '0;
                c0.addr = ADDR_W'(n) << OFS_W;
                run_ops(2'b11, c0, c0);
            end
            pulse_flush();
            for (int n = 0; n < 8; n++) begin
                c0      = '0;
                c0.addr = ADDR_W'(n) << OFS_W;
                run_ops(2'b11, c0, c0);  // every line misses again
            end
            report_test("flush", errs);

            errs = error_count;
            c0      = '0;
            c0.addr = 32'h8000_0040;
            run_ops(2'b10, '0, c0);
            run_ops(2'b10, '0, c0);
            c0.wr    = 1'b1;
            c0.wdata = 32'h1234_5678;
            c0.strb  = 4'hf;
            c0.addr  = 32'h8000_0044;
            run_ops(2'b01, c0, '0);
            c0.wr     = 1'b0;
            c0.bypass = 1'b1;
            c0.addr   = 32'h8000_0048;
            run_ops(2'b01, c0, '0);
            c0.bypass = 1'b0;
            c1        = c0;
            c1.addr   = 32'h8000_0080;
            run_ops(2'b11, c0, c1);
            report_test("bus_error", errs);

            errs = error_count;
            for (int n = 0; n < 12; n++) begin
                pulse_flush();
                c0 = random_cmd(1'b1);
                c1 = random_cmd(1'b1);
                run_ops(2'b11, c0, c1);
            end
            report_test("dual_miss", errs);

            $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
            if (error_count == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

// 20 ns clock, reset held low for the first 16 cycles
module tb_clock (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== design/cache_subsys.sv ====
`timescale 1ns/1ns
`default_nettype none

// instruction cache on arbiter port 0, data cache on port 1
module cache_subsys
    import cache_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rstn,
    input  wire logic         i_req,
    input  wire core_req_t    i_cmd,
    output logic              i_busy,
    output logic [DATA_W-1:0] i_rdata,
    output logic              i_err,
    input  wire logic         d_req,
    input  wire core_req_t    d_cmd,
    output logic              d_busy,
    output logic [DATA_W-1:0] d_rdata,
    output logic              d_err,
    input  wire logic         flush,
    output mem_req_t          mem_req,
    output logic              mem_req_valid,
    input  wire logic         mem_req_ready,
    input  wire mem_rsp_t     mem_rsp
);

    mem_req_t [1:0] cache_req;
    logic [1:0]     cache_req_valid;
    logic [1:0]     cache_req_ready;
    mem_rsp_t [1:0] cache_rsp;

    l1_cache icache_i (
        .clk (clk), .rstn (rstn),
        .core_req (i_req), .core_cmd (i_cmd), .flush (flush),
        .busy (i_busy), .rdata (i_rdata), .err (i_err),
        .mem_req (cache_req[0]), .mem_req_valid (cache_req_valid[0]),
        .mem_req_ready (cache_req_ready[0]), .mem_rsp (cache_rsp[0])
    );

    l1_cache dcache_i (
        .clk (clk), .rstn (rstn),
        .core_req (d_req), .core_cmd (d_cmd), .flush (flush),
        .busy (d_busy), .rdata (d_rdata), .err (d_err),
        .mem_req (cache_req[1]), .mem_req_valid (cache_req_valid[1]),
        .mem_req_ready (cache_req_ready[1]), .mem_rsp (cache_rsp[1])
    );

    bus_arbiter arbiter_i (
        .clk (clk), .rstn (rstn),
        .req (cache_req), .req_valid (cache_req_valid), .req_ready (cache_req_ready),
        .rsp (cache_rsp),
        .bus_req (mem_req), .bus_req_valid (mem_req_valid),
        .bus_req_ready (mem_req_ready), .bus_rsp (mem_rsp)
    );

endmodule

`default_nettype wire

// ==== design/bus_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

// round robin between the two caches, one whole transaction at a time
module bus_arbiter
    import cache_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           rstn,
    input  wire mem_req_t [1:0] req,
    input  wire logic [1:0]     req_valid,
    output logic [1:0]          req_ready,
    output mem_rsp_t [1:0]      rsp,
    output mem_req_t            bus_req,
    output logic                bus_req_valid,
    input  wire logic           bus_req_ready,
    input  wire mem_rsp_t       bus_rsp
);

    logic owner;    // port that holds the bus or waits on ready
    logic locked;   // request accepted, waiting for the last beat
    logic pending;  // request shown to the bus and not yet accepted
    logic prio;
    logic pick;
    logic sel;

    assign pick          = req_valid[prio] ? prio : !prio;
    assign sel           = (locked || pending) ? owner : pick;
    assign bus_req       = req[sel];
    assign bus_req_valid = !locked && req_valid[sel];

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            req_ready[i] = !locked && (sel == 1'(i)) && bus_req_ready;
            rsp[i]       = bus_rsp;
            rsp[i].valid = bus_rsp.valid && locked && (owner == 1'(i));
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            owner   <= 1'b0;
            locked  <= 1'b0;
            pending <= 1'b0;
            prio    <= 1'b0;
        end else if (bus_req_valid) begin
            owner   <= sel;
            pending <= !bus_req_ready;
            locked  <= bus_req_ready;
        end else if (locked && bus_rsp.valid && bus_rsp.last) begin
            locked <= 1'b0;
            prio   <= !owner;  // the other port wins the next tie
        end
    end

    a_rsp_locked: assert property (@(posedge clk) disable iff (!rstn)
        bus_rsp.valid |-> locked);

endmodule

`default_nettype wire

// ==== design/l1_cache.sv ====
`timescale 1ns/1ns
`default_nettype none

// direct mapped write-through cache with no allocation on writes
module l1_cache
    import cache_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rstn,
    input  wire logic         core_req,
    input  wire core_req_t    core_cmd,
    input  wire logic         flush,
    output logic              busy,
    output logic [DATA_W-1:0] rdata,
    output logic              err,
    output mem_req_t          mem_req,
    output logic              mem_req_valid,
    input  wire logic         mem_req_ready,
    input  wire mem_rsp_t     mem_rsp
);

    cache_state_e                        state;
    cache_state_e                        state_nxt;
    core_req_t                           cmd_q;
    logic [LINES-1:0]                    valid;
    logic [$clog2(WORDS_PER_LINE)-1:0]   beat_cnt;
    logic                                req_sent;
    logic [DATA_W-1:0]                   rdata_q;

    logic                                accept;
    logic                                hit;
    logic                                last_beat;
    logic [IDX_W-1:0]                    idx_q;
    logic [IDX_W-1:0]                    ram_idx;
    logic [TAG_W-1:0]                    tag_q;
    logic [TAG_W-1:0]                    tag_out;
    logic [$clog2(WORDS_PER_LINE)-1:0]   word_q;
    logic [LINE_W-1:0]                   line_out;
    logic [DATA_W-1:0]                   hit_word;
    logic                                tag_cs;
    logic                                tag_we;
    logic                                data_cs;
    logic                                data_we;
    logic [LINE_BYTES-1:0]               data_be;
    logic [LINE_W-1:0]                   data_in;

    assign idx_q     = cmd_q.addr[OFS_W +: IDX_W];
    assign tag_q     = cmd_q.addr[OFS_W+IDX_W +: TAG_W];
    assign word_q    = cmd_q.addr[$clog2(STRB_W) +: $clog2(WORDS_PER_LINE)];
    assign accept    = core_req && !busy;
    assign ram_idx   = accept ? core_cmd.addr[OFS_W +: IDX_W] : idx_q;
    assign hit       = valid[idx_q] && (tag_out == tag_q);  // tag RAM is idle until the next accept
    assign hit_word  = line_out[word_q*DATA_W +: DATA_W];
    assign last_beat = mem_rsp.valid && mem_rsp.last;
    assign rdata     = (state == S_LOOKUP) ? hit_word : rdata_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (accept) state_nxt = S_LOOKUP;
            end
            S_LOOKUP: begin
                if (cmd_q.wr)          state_nxt = S_WRITE;
                else if (cmd_q.bypass) state_nxt = S_BYPASS;
                else if (!hit)         state_nxt = S_FILL_REQ;
                else if (!accept)      state_nxt = S_IDLE;   // back to back hits stay here
            end
            S_FILL_REQ: begin
                if (mem_req_ready) state_nxt = S_FILL;
            end
            S_FILL, S_WRITE, S_BYPASS: begin
                if (last_beat) state_nxt = S_IDLE;
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_comb begin
        case (state)
            S_IDLE:   busy = 1'b0;
            S_LOOKUP: busy = cmd_q.wr || cmd_q.bypass || !hit;
            default:  busy = 1'b1;
        endcase
    end

    always_comb begin
        tag_cs  = accept;
        tag_we  = 1'b0;
        data_cs = accept;
        data_we = 1'b0;
        data_be = '0;
        data_in = {WORDS_PER_LINE{mem_rsp.rdata}};
        case (state)
            S_FILL: begin
                data_cs = mem_rsp.valid;
                data_we = mem_rsp.valid;
                data_be = {{(LINE_BYTES-STRB_W){1'b0}}, {STRB_W{1'b1}}} << (beat_cnt * STRB_W);
                tag_cs  = last_beat;
                tag_we  = last_beat;
            end
            S_WRITE: begin
                // update in place only once memory has taken the write
                data_cs = last_beat && !mem_rsp.err && hit;
                data_we = 1'b1;
                data_be = {{(LINE_BYTES-STRB_W){1'b0}}, cmd_q.strb} << (word_q * STRB_W);
                data_in = {WORDS_PER_LINE{cmd_q.wdata}};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) cmd_q <= core_cmd;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (state == S_FILL && last_beat) begin
            valid[idx_q] <= !(err || mem_rsp.err);  // any bad beat keeps the line out
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            err      <= 1'b0;
            beat_cnt <= '0;
            req_sent <= 1'b0;
        end else if (accept) begin
            err      <= 1'b0;
            beat_cnt <= '0;
            req_sent <= 1'b0;
        end else begin
            if (mem_rsp.valid && mem_rsp.err)   err <= 1'b1;
            if (mem_rsp.valid)                  beat_cnt <= beat_cnt + 1'b1;
            if (mem_req_valid && mem_req_ready) req_sent <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_LOOKUP && !busy) begin
            rdata_q <= hit_word;
        end else if (mem_rsp.valid &&
                     (state == S_BYPASS || (state == S_FILL && beat_cnt == word_q))) begin
            rdata_q <= mem_rsp.rdata;
        end
    end

    assign mem_req_valid = (state == S_FILL_REQ) ||
                           ((state == S_WRITE || state == S_BYPASS) && !req_sent);

    always_comb begin
        mem_req.op    = (state == S_WRITE) ? MEM_WRITE : MEM_READ;
        mem_req.addr  = (state == S_FILL_REQ) ? {cmd_q.addr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}}
                                              : cmd_q.addr;
        mem_req.wdata = cmd_q.wdata;
        mem_req.strb  = (state == S_WRITE) ? cmd_q.strb : {STRB_W{1'b1}};
        mem_req.len   = (state == S_FILL_REQ) ? 2'(WORDS_PER_LINE - 1) : 2'd0;
    end

    cache_ram #(.WIDTH(TAG_W)) tag_ram_i (
        .clk  (clk),
        .cs   (tag_cs),
        .we   (tag_we),
        .addr (ram_idx),
        .be   ('1),
        .din  (tag_q),
        .dout (tag_out)
    );

    cache_ram #(.WIDTH(LINE_W)) data_ram_i (
        .clk  (clk),
        .cs   (data_cs),
        .we   (data_we),
        .addr (ram_idx),
        .be   (data_be),
        .din  (data_in),
        .dout (line_out)
    );

    // the memory side must close a line fill on its fourth beat
    a_fill_len: assert property (@(posedge clk) disable iff (!rstn)
        state == S_FILL && mem_rsp.valid && beat_cnt == 2'(WORDS_PER_LINE - 1)
        |-> mem_rsp.last);

    a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

endmodule

`default_nettype wire

// ==== design/cache_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

// one row per cache line, read data appears the cycle after cs
module cache_ram
    import cache_pkg::*;
#(
    parameter int WIDTH = LINE_W
) (
    input  wire logic                   clk,
    input  wire logic                   cs,
    input  wire logic                   we,
    input  wire logic [IDX_W-1:0]       addr,
    input  wire logic [(WIDTH+7)/8-1:0] be,
    input  wire logic [WIDTH-1:0]       din,
    output logic      [WIDTH-1:0]       dout
);

    logic [WIDTH-1:0] mem [LINES];

    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                // a partial top byte is covered by its own enable bit
                for (int i = 0; i < WIDTH; i++) begin
                    if (be[i/8]) begin
                        mem[addr][i] <= din[i];
                    end
                end
            end
            dout <= mem[addr];  // a write cycle returns the old row
        end
    end

endmodule

`default_nettype wire

// ==== design/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int STRB_W         = DATA_W / 8;
    localparam int LINE_BYTES     = 16;
    localparam int WORDS_PER_LINE = LINE_BYTES / STRB_W;
    localparam int OFS_W          = 4;                      // byte offset within a line
    localparam int IDX_W          = 6;
    localparam int LINES          = 1 << IDX_W;
    localparam int TAG_W          = ADDR_W - IDX_W - OFS_W; // everything above the index
    localparam int LINE_W         = LINE_BYTES * 8;         // one data RAM row

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_FILL_REQ,
        S_FILL,
        S_WRITE,
        S_BYPASS
    } cache_state_e;

    // one core access, sampled together with core_req
    typedef struct packed {
        logic              wr;
        logic              bypass;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
    } core_req_t;

    typedef struct packed {
        mem_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
        logic [1:0]        len;   // beats minus one
    } mem_req_t;

    // response beats are always accepted so there is no ready here
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] rdata;
        logic              last;
        logic              err;
    } mem_rsp_t;

endpackage

`default_nettype wire
